// ==== hdl/i2c_pkg.sv ====
//**************************************************************************
// i2c master shared types
// address, byte and counter types, FSM state encodings and the
// bit-level command codes passed from byte controller to bit engine
//**************************************************************************

`default_nettype none

package i2c_pkg;

  // bits per byte on the bus and on both streams
  localparam int BYTE_BITS = 8;

  // 7-bit target address
  typedef logic [6:0] addr_t;

  typedef logic [BYTE_BITS-1:0] byte_t;

  // counts 0..8 bits of a byte
  typedef logic [3:0] bit_cnt_t;

  // bit engine commands, one-cycle strobes
  typedef enum logic [2:0] {
    PHY_NONE,
    PHY_START,
    PHY_WRITE,
    PHY_READ,
    PHY_STOP
  } phy_cmd_t;

  // byte controller FSM
  typedef enum logic [3:0] {
    CTRL_IDLE,
    CTRL_START,
    CTRL_ADDR,
    CTRL_ADDR_ACK,
    CTRL_WR_FETCH,
    CTRL_WR_BITS,
    CTRL_WR_ACK,
    CTRL_RD_BITS,
    CTRL_RD_NACK,
    CTRL_DRAIN,
    CTRL_STOP
  } ctrl_state_t;

  // bit engine FSM, quarter index kept alongside
  typedef enum logic [2:0] {
    PHY_ST_IDLE,
    PHY_ST_START,
    PHY_ST_WR_QTR,
    PHY_ST_RD_QTR,
    PHY_ST_STOP
  } phy_state_t;

endpackage

`default_nettype wire

// ==== hdl/i2c_bit_phy.sv ====
//**************************************************************************
// i2c bit engine
// generates START, one data bit or STOP on open-drain SCL/SDA with
// quarter-period timing, honours clock stretching by the target
//**************************************************************************

`timescale 1ns/1ns
`default_nettype none

module i2c_bit_phy #(
  parameter int unsigned PRESCALE = 4
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  i2c_pkg::phy_cmd_t   phy_cmd_i,
  input  wire                 phy_tx_bit_i,
  output logic                phy_busy_o,
  output logic                phy_rx_bit_o,
  input  wire                 scl_i,
  output logic                scl_o,
  input  wire                 sda_i,
  output logic                sda_o
);

  // quarter counter sizing
  localparam int CNT_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PRESCALE - 1);

  i2c_pkg::phy_state_t state_q;
  logic [1:0]          qtr_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [1:0]          scl_sync_q;
  logic [1:0]          sda_sync_q;
  logic                scl_o_q;
  logic                sda_o_q;
  logic                rx_q;
  logic                scl_in;
  logic                sda_in;
  logic                wait_hi;
  logic                last_qtr;
  logic                qtr_end;

  // synchronised bus inputs
  assign scl_in = scl_sync_q[1];
  assign sda_in = sda_sync_q[1];

  // high quarter held open while target stretches SCL
  assign wait_hi = (qtr_q == 2'd1) && (state_q != i2c_pkg::PHY_ST_START) && !scl_in;

  // START is 2 quarters, STOP 3, data bit 4
  always_comb begin
    case (state_q)
      i2c_pkg::PHY_ST_START: last_qtr = (qtr_q == 2'd1);
      i2c_pkg::PHY_ST_STOP:  last_qtr = (qtr_q == 2'd2);
      default:               last_qtr = (qtr_q == 2'd3);
    endcase
  end

  assign qtr_end = (state_q != i2c_pkg::PHY_ST_IDLE) && (cnt_q == '0) && !wait_hi;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= i2c_pkg::PHY_ST_IDLE;
      qtr_q      <= '0;
      cnt_q      <= CNT_LOAD;
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_o_q    <= 1'b1;
      sda_o_q    <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      if (state_q == i2c_pkg::PHY_ST_IDLE) begin
        cnt_q <= CNT_LOAD;
        qtr_q <= '0;
        case (phy_cmd_i)
          i2c_pkg::PHY_START: begin
            // both lines released before SDA falls
            state_q <= i2c_pkg::PHY_ST_START;
            scl_o_q <= 1'b1;
            sda_o_q <= 1'b1;
          end
          i2c_pkg::PHY_WRITE: begin
            // SCL is low here, data set up now
            state_q <= i2c_pkg::PHY_ST_WR_QTR;
            sda_o_q <= phy_tx_bit_i;
          end
          i2c_pkg::PHY_READ: begin
            state_q <= i2c_pkg::PHY_ST_RD_QTR;
            sda_o_q <= 1'b1;
          end
          i2c_pkg::PHY_STOP: begin
            state_q <= i2c_pkg::PHY_ST_STOP;
            sda_o_q <= 1'b0;
          end
          default: begin
            state_q <= i2c_pkg::PHY_ST_IDLE;
          end
        endcase
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else if (qtr_end) begin
        cnt_q <= CNT_LOAD;
        qtr_q <= qtr_q + 2'd1;
        if (last_qtr) begin
          state_q <= i2c_pkg::PHY_ST_IDLE;
        end
        case (state_q)
          i2c_pkg::PHY_ST_START: begin
            // SDA falls with SCL high, then SCL pulled low
            if (qtr_q == 2'd0) begin
              sda_o_q <= 1'b0;
            end else begin
              scl_o_q <= 1'b0;
            end
          end
          i2c_pkg::PHY_ST_STOP: begin
            // SCL up first, SDA rises while SCL high
            if (qtr_q == 2'd0) begin
              scl_o_q <= 1'b1;
            end else if (qtr_q == 2'd1) begin
              sda_o_q <= 1'b1;
            end
          end
          default: begin
            // release SCL after setup, pull low after high phase
            if (qtr_q == 2'd0) begin
              scl_o_q <= 1'b1;
            end else if (qtr_q == 2'd2) begin
              scl_o_q <= 1'b0;
            end
          end
        endcase
      end
    end
  end

  // sample mid high phase, held until next read
  always_ff @(posedge clk) begin
    if (qtr_end && state_q == i2c_pkg::PHY_ST_RD_QTR && qtr_q == 2'd1) begin
      rx_q <= sda_in;
    end
  end

  assign phy_busy_o   = (state_q != i2c_pkg::PHY_ST_IDLE);
  assign phy_rx_bit_o = rx_q;
  assign scl_o        = scl_o_q;
  assign sda_o        = sda_o_q;

  // controller only issues commands while engine is idle
  a_no_cmd_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    phy_busy_o |-> (phy_cmd_i == i2c_pkg::PHY_NONE)
  );

endmodule

`default_nettype wire

// ==== hdl/i2c_byte_ctrl.sv ====
//**************************************************************************
// i2c byte controller
// sequences START, address, write bytes or one read byte, ACK/NACK
// and STOP over the bit engine, with command and data handshakes
//**************************************************************************

`timescale 1ns/1ns
`default_nettype none

module i2c_byte_ctrl (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 cmd_valid_i,
  output logic                cmd_ready_o,
  input  i2c_pkg::addr_t      cmd_addr_i,
  input  wire                 cmd_read_i,
  input  i2c_pkg::byte_t      wr_data_i,
  input  wire                 wr_last_i,
  input  wire                 wr_valid_i,
  output logic                wr_ready_o,
  output i2c_pkg::byte_t      rd_data_o,
  output logic                rd_last_o,
  output logic                rd_valid_o,
  input  wire                 rd_ready_i,
  output logic                busy_o,
  output logic                missed_ack_o,
  output i2c_pkg::phy_cmd_t   phy_cmd_o,
  output logic                phy_tx_bit_o,
  input  wire                 phy_busy_i,
  input  wire                 phy_rx_bit_i
);

  localparam i2c_pkg::bit_cnt_t BITS_LOAD = i2c_pkg::bit_cnt_t'(i2c_pkg::BYTE_BITS);

  i2c_pkg::ctrl_state_t state_q, state_d;
  i2c_pkg::bit_cnt_t    bit_cnt_q, bit_cnt_d;
  i2c_pkg::byte_t       shift_q, shift_d;
  i2c_pkg::byte_t       shift_in;
  i2c_pkg::byte_t       rd_data_q, rd_data_d;
  logic                 read_q, read_d;
  logic                 last_q, last_d;
  logic                 drain_q, drain_d;
  logic                 rd_valid_q, rd_valid_d;
  logic                 cmd_ready_q;
  logic                 busy_q;
  logic                 missed_q, missed_d;
  logic                 go;

  // bit engine free, previous bit finished
  assign go = !phy_busy_i;
  assign shift_in = {shift_q[i2c_pkg::BYTE_BITS-2:0], phy_rx_bit_i};

  // write stream taken while fetching or draining after NACK
  assign wr_ready_o = (state_q == i2c_pkg::CTRL_WR_FETCH) ||
                      (state_q == i2c_pkg::CTRL_DRAIN && drain_q);

  always_comb begin
    state_d      = state_q;
    bit_cnt_d    = bit_cnt_q;
    shift_d      = shift_q;
    rd_data_d    = rd_data_q;
    read_d       = read_q;
    last_d       = last_q;
    drain_d      = drain_q;
    missed_d     = 1'b0;
    rd_valid_d   = rd_valid_q && !rd_ready_i;
    phy_cmd_o    = i2c_pkg::PHY_NONE;
    phy_tx_bit_o = 1'b0;
    case (state_q)
      i2c_pkg::CTRL_IDLE: begin
        if (cmd_valid_i && cmd_ready_q) begin
          // address and R/W go out as one byte
          shift_d = {cmd_addr_i, cmd_read_i};
          read_d  = cmd_read_i;
          state_d = i2c_pkg::CTRL_START;
        end
      end
      i2c_pkg::CTRL_START: begin
        if (go) begin
          phy_cmd_o = i2c_pkg::PHY_START;
          bit_cnt_d = BITS_LOAD;
          state_d   = i2c_pkg::CTRL_ADDR;
        end
      end
      i2c_pkg::CTRL_ADDR, i2c_pkg::CTRL_WR_BITS: begin
        if (go) begin
          if (bit_cnt_q != '0) begin
            // msb first
            phy_cmd_o    = i2c_pkg::PHY_WRITE;
            phy_tx_bit_o = shift_q[i2c_pkg::BYTE_BITS-1];
            shift_d      = shift_q << 1;
            bit_cnt_d    = bit_cnt_q - 1'b1;
          end else begin
            // ACK slot from target
            phy_cmd_o = i2c_pkg::PHY_READ;
            state_d   = (state_q == i2c_pkg::CTRL_ADDR) ? i2c_pkg::CTRL_ADDR_ACK :
                                                          i2c_pkg::CTRL_WR_ACK;
          end
        end
      end
      i2c_pkg::CTRL_ADDR_ACK: begin
        if (go) begin
          if (phy_rx_bit_i) begin
            // no target, writes still owe their bytes
            missed_d = 1'b1;
            drain_d  = !read_q;
            state_d  = i2c_pkg::CTRL_DRAIN;
          end else if (read_q) begin
            bit_cnt_d = BITS_LOAD;
            state_d   = i2c_pkg::CTRL_RD_BITS;
          end else begin
            state_d = i2c_pkg::CTRL_WR_FETCH;
          end
        end
      end
      i2c_pkg::CTRL_WR_FETCH: begin
        // SCL stays low until a byte shows up
        if (wr_valid_i) begin
          shift_d   = wr_data_i;
          last_d    = wr_last_i;
          bit_cnt_d = BITS_LOAD;
          state_d   = i2c_pkg::CTRL_WR_BITS;
        end
      end
      i2c_pkg::CTRL_WR_ACK: begin
        if (go) begin
          if (phy_rx_bit_i) begin
            missed_d = 1'b1;
            drain_d  = !last_q;
            state_d  = i2c_pkg::CTRL_DRAIN;
          end else if (last_q) begin
            phy_cmd_o = i2c_pkg::PHY_STOP;
            state_d   = i2c_pkg::CTRL_STOP;
          end else begin
            state_d = i2c_pkg::CTRL_WR_FETCH;
          end
        end
      end
      i2c_pkg::CTRL_RD_BITS: begin
        if (go) begin
          // first shift pulls in a stale bit, pushed out by the 8 after it
          shift_d = shift_in;
          if (bit_cnt_q != '0) begin
            phy_cmd_o = i2c_pkg::PHY_READ;
            bit_cnt_d = bit_cnt_q - 1'b1;
          end else begin
            // NACK ends the single-byte read
            phy_cmd_o    = i2c_pkg::PHY_WRITE;
            phy_tx_bit_o = 1'b1;
            rd_data_d    = shift_in;
            rd_valid_d   = 1'b1;
            state_d      = i2c_pkg::CTRL_RD_NACK;
          end
        end
      end
      i2c_pkg::CTRL_RD_NACK: begin
        if (go) begin
          phy_cmd_o = i2c_pkg::PHY_STOP;
          state_d   = i2c_pkg::CTRL_STOP;
        end
      end
      i2c_pkg::CTRL_DRAIN: begin
        // discard rest of burst up to last
        if (drain_q) begin
          if (wr_valid_i && wr_last_i) begin
            drain_d = 1'b0;
          end
        end else if (go) begin
          phy_cmd_o = i2c_pkg::PHY_STOP;
          state_d   = i2c_pkg::CTRL_STOP;
        end
      end
      i2c_pkg::CTRL_STOP: begin
        // wait for STOP to finish on the bus
        if (go) begin
          state_d = i2c_pkg::CTRL_IDLE;
        end
      end
      default: begin
        state_d = i2c_pkg::CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= i2c_pkg::CTRL_IDLE;
      bit_cnt_q   <= '0;
      read_q      <= 1'b0;
      drain_q     <= 1'b0;
      rd_valid_q  <= 1'b0;
      cmd_ready_q <= 1'b0;
      busy_q      <= 1'b0;
      missed_q    <= 1'b0;
    end else begin
      state_q     <= state_d;
      bit_cnt_q   <= bit_cnt_d;
      read_q      <= read_d;
      drain_q     <= drain_d;
      rd_valid_q  <= rd_valid_d;
      // next command waits for pending read byte
      cmd_ready_q <= (state_d == i2c_pkg::CTRL_IDLE) && !rd_valid_d;
      busy_q      <= (state_d != i2c_pkg::CTRL_IDLE);
      missed_q    <= missed_d;
    end
  end

  // data path
  always_ff @(posedge clk) begin
    shift_q   <= shift_d;
    last_q    <= last_d;
    rd_data_q <= rd_data_d;
  end

  assign cmd_ready_o  = cmd_ready_q;
  assign busy_o       = busy_q;
  assign missed_ack_o = missed_q;
  assign rd_data_o    = rd_data_q;
  assign rd_valid_o   = rd_valid_q;
  // single-byte reads, every byte is the last
  assign rd_last_o    = rd_valid_q;

  a_rd_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_data_o))
  );

endmodule

`default_nettype wire

// ==== hdl/i2c_master.sv ====
//**************************************************************************
// i2c master top level
// byte controller over the bit engine, bus quarter period set by PRESCALE
//**************************************************************************

`timescale 1ns/1ns
`default_nettype none

module i2c_master #(
  parameter int unsigned PRESCALE = 4
) (
  input  wire              clk,
  input  wire              rst_n,
  // command port
  input  wire              cmd_valid_i,
  output logic             cmd_ready_o,
  input  i2c_pkg::addr_t   cmd_addr_i,
  input  wire              cmd_read_i,
  // write stream
  input  i2c_pkg::byte_t   wr_data_i,
  input  wire              wr_last_i,
  input  wire              wr_valid_i,
  output logic             wr_ready_o,
  // read stream
  output i2c_pkg::byte_t   rd_data_o,
  output logic             rd_last_o,
  output logic             rd_valid_o,
  input  wire              rd_ready_i,
  // open drain, high releases the line
  input  wire              scl_i,
  output logic             scl_o,
  input  wire              sda_i,
  output logic             sda_o,
  // status
  output logic             busy_o,
  output logic             missed_ack_o
);

  i2c_pkg::phy_cmd_t phy_cmd;
  logic              phy_tx_bit;
  logic              phy_busy;
  logic              phy_rx_bit;

  i2c_byte_ctrl i_byte_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_read_i   (cmd_read_i),
    .wr_data_i    (wr_data_i),
    .wr_last_i    (wr_last_i),
    .wr_valid_i   (wr_valid_i),
    .wr_ready_o   (wr_ready_o),
    .rd_data_o    (rd_data_o),
    .rd_last_o    (rd_last_o),
    .rd_valid_o   (rd_valid_o),
    .rd_ready_i   (rd_ready_i),
    .busy_o       (busy_o),
    .missed_ack_o (missed_ack_o),
    .phy_cmd_o    (phy_cmd),
    .phy_tx_bit_o (phy_tx_bit),
    .phy_busy_i   (phy_busy),
    .phy_rx_bit_i (phy_rx_bit)
  );

  i2c_bit_phy #(
    .PRESCALE (PRESCALE)
  ) i_bit_phy (
    .clk          (clk),
    .rst_n        (rst_n),
    .phy_cmd_i    (phy_cmd),
    .phy_tx_bit_i (phy_tx_bit),
    .phy_busy_o   (phy_busy),
    .phy_rx_bit_o (phy_rx_bit),
    .scl_i        (scl_i),
    .scl_o        (scl_o),
    .sda_i        (sda_i),
    .sda_o        (sda_o)
  );

endmodule

`default_nettype wire

// ==== test/i2c_target_model.sv ====
//**************************************************************************
// behavioural i2c target
// acks one address, stores write bursts, answers a read with the byte
// sum of the last acked burst, stretches SCL by random quarter periods
//**************************************************************************

`timescale 1ns/1ns
`default_nettype none

module i2c_target_model #(
  parameter i2c_pkg::addr_t ADDR   = 7'h50,
  parameter int             QTR_NS = 80,
  parameter int             SEED   = 32'h8c3c
) (
  input  wire  scl_i,
  input  wire  sda_i,
  output logic scl_o,
  output logic sda_o
);

  typedef enum logic [2:0] {
    T_IDLE,
    T_ADDR,
    T_WRITE,
    T_READ,
    T_IGNORE
  } tgt_phase_t;

  tgt_phase_t     phase;
  int             count;
  int             burst_len;
  int             stretch;
  integer         seed;
  logic           rw;
  logic           scl_q;
  logic           sda_q;
  i2c_pkg::byte_t shreg;
  i2c_pkg::byte_t tx_byte;
  i2c_pkg::byte_t mem [0:15];

  // byte sum of the stored burst, modulo 256
  function automatic i2c_pkg::byte_t burst_sum();
    i2c_pkg::byte_t s;
    s = '0;
    for (int i = 0; i < burst_len; i++) begin
      s = s + mem[i];
    end
    return s;
  endfunction

  initial begin
    phase     = T_IDLE;
    count     = 0;
    burst_len = 0;
    stretch   = 0;
    seed      = SEED;
    rw        = 1'b0;
    shreg     = '0;
    tx_byte   = '0;
    scl_q     = 1'b1;
    sda_q     = 1'b1;
    scl_o     = 1'b1;
    sda_o     = 1'b1;
  end

  // bus decoder, one process for all line changes
  always @(scl_i or sda_i) begin
    if (scl_i === 1'b1 && scl_q === 1'b1 && sda_i !== sda_q) begin
      // SDA edge with SCL high: fall is START, rise is STOP
      if (sda_i === 1'b0) begin
        phase = T_ADDR;
        count = 0;
      end else begin
        phase = T_IDLE;
      end
    end else if (scl_i === 1'b1 && scl_q === 1'b0) begin
      // rising SCL, bit sampled
      if (phase == T_ADDR || phase == T_WRITE || phase == T_READ) begin
        if (count < 8) begin
          shreg = {shreg[6:0], sda_i};
        end
        count = count + 1;
      end
    end else if (scl_i === 1'b0 && scl_q === 1'b1) begin
      // falling SCL, next bit placed on SDA
      case (phase)
        T_ADDR: begin
          if (count == 8) begin
            if (shreg[7:1] == ADDR) begin
              rw    = shreg[0];
              sda_o = 1'b0;
              if (!rw) begin
                burst_len = 0;
              end
            end else begin
              phase = T_IGNORE;
            end
          end else if (count == 9) begin
            count = 0;
            if (rw) begin
              tx_byte = burst_sum();
              sda_o   = tx_byte[7];
              phase   = T_READ;
            end else begin
              sda_o = 1'b1;
              phase = T_WRITE;
            end
          end
        end
        T_WRITE: begin
          if (count == 8) begin
            if (burst_len < 16) begin
              mem[burst_len] = shreg;
            end
            burst_len = burst_len + 1;
            sda_o     = 1'b0;
          end else if (count == 9) begin
            count = 0;
            sda_o = 1'b1;
          end
        end
        T_READ: begin
          if (count < 8) begin
            sda_o = tx_byte[7-count];
          end else if (count == 8) begin
            // master answers with NACK
            sda_o = 1'b1;
          end else begin
            count = 0;
            phase = T_IDLE;
          end
        end
        default: begin
        end
      endcase
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

  // clock stretch after each SCL fall, release lands between clk edges
  always @(negedge scl_i) begin
    stretch = $unsigned($random(seed)) % 4;
    if (stretch != 0) begin
      scl_o = 1'b0;
      #(stretch * QTR_NS + 5);
      scl_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_i2c_master.sv ====
//**************************************************************************
// i2c master testbench
// write bursts and checksum reads against a behavioural target,
// plus a write to an absent address that must end in missed ACK
//**************************************************************************

`timescale 1ns/1ns
`default_nettype none

module tb_i2c_master;

  localparam int  PRESCALE   = 4;
  localparam int  WAIT_LIMIT = 4000;
  // 20 transactions x 50 bits x 16 cycles x 2 stretch x 20 ns ~ 640 us
  localparam time WATCHDOG   = 1_000_000;

  localparam int SEL_CMD_READY = 0;
  localparam int SEL_WR_READY  = 1;
  localparam int SEL_RD_VALID  = 2;
  localparam int SEL_IDLE      = 3;

  logic           clk;
  logic           rst_n;
  logic           cmd_valid_i;
  logic           cmd_ready_o;
  i2c_pkg::addr_t cmd_addr_i;
  logic           cmd_read_i;
  i2c_pkg::byte_t wr_data_i;
  logic           wr_last_i;
  logic           wr_valid_i;
  logic           wr_ready_o;
  i2c_pkg::byte_t rd_data_o;
  logic           rd_last_o;
  logic           rd_valid_o;
  logic           rd_ready_i;
  logic           busy_o;
  logic           missed_ack_o;
  logic           dut_scl;
  logic           dut_sda;
  logic           tgt_scl;
  logic           tgt_sda;
  wire            scl;
  wire            sda;

  integer         seed;
  int             checks;
  int             value_errs;
  int             other_errs;
  int             miss_cycles;
  int             rd_valid_cycles;
  int             rd_taken;
  i2c_pkg::byte_t exp_rd;
  i2c_pkg::byte_t burst_q[$];

  // wired-AND open-drain bus with pull-ups
  assign scl = dut_scl & tgt_scl;
  assign sda = dut_sda & tgt_sda;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  i2c_master #(
    .PRESCALE (PRESCALE)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_read_i   (cmd_read_i),
    .wr_data_i    (wr_data_i),
    .wr_last_i    (wr_last_i),
    .wr_valid_i   (wr_valid_i),
    .wr_ready_o   (wr_ready_o),
    .rd_data_o    (rd_data_o),
    .rd_last_o    (rd_last_o),
    .rd_valid_o   (rd_valid_o),
    .rd_ready_i   (rd_ready_i),
    .scl_i        (scl),
    .scl_o        (dut_scl),
    .sda_i        (sda),
    .sda_o        (dut_sda),
    .busy_o       (busy_o),
    .missed_ack_o (missed_ack_o)
  );

  i2c_target_model #(
    .ADDR   (7'h50),
    .QTR_NS (PRESCALE * 20),
    .SEED   (32'h8c3c)
  ) i_target (
    .scl_i (scl),
    .sda_i (sda),
    .scl_o (tgt_scl),
    .sda_o (tgt_sda)
  );

  // byte sum modulo 256 of the last burst sent
  function automatic i2c_pkg::byte_t expected_read(input i2c_pkg::byte_t data[$]);
    i2c_pkg::byte_t sum;
    sum = '0;
    foreach (data[i]) begin
      sum = sum + data[i];
    end
    return sum;
  endfunction

  task automatic check_byte(input string name, input i2c_pkg::byte_t act,
                            input i2c_pkg::byte_t exp);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0t ns: %s is 8'h%02h, expected 8'h%02h", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_CMD_READY: return cmd_ready_o;
      SEL_WR_READY:  return wr_ready_o;
      SEL_RD_VALID:  return rd_valid_o;
      default:       return !busy_o;
    endcase
  endfunction

  // returns on the falling clk edge where the condition holds
  task automatic await_signal(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!probe(sel) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!probe(sel)) begin
      other_errs++;
      $display("timeout at %0t ns: waited %0d cycles for %s", $time, WAIT_LIMIT, what);
    end
  endtask

  task automatic send_cmd(input i2c_pkg::addr_t addr, input logic rd);
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_read_i  = rd;
    await_signal(SEL_CMD_READY, "cmd_ready_o");
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b0;
  endtask

  // gaps with wr_valid_i low after wr_ready_o rises hold SCL low in WR_FETCH
  task automatic write_burst(input i2c_pkg::addr_t addr, input int max_gap);
    int gap;
    send_cmd(addr, 1'b0);
    foreach (burst_q[i]) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      await_signal(SEL_WR_READY, "wr_ready_o");
      repeat (gap) begin
        @(negedge clk);
        check_bit("scl_o (stalled)", dut_scl, 1'b0);
      end
      @(posedge clk);
      #2;
      wr_valid_i = 1'b1;
      wr_data_i  = burst_q[i];
      wr_last_i  = (i == burst_q.size() - 1);
      await_signal(SEL_WR_READY, "wr_ready_o");
      @(posedge clk);
      #2;
      wr_valid_i = 1'b0;
      wr_last_i  = 1'b0;
    end
    await_signal(SEL_IDLE, "busy_o to fall");
  endtask

  task automatic read_check(input i2c_pkg::addr_t addr);
    int             hold;
    int             taken;
    i2c_pkg::byte_t held;
    exp_rd = expected_read(burst_q);
    taken  = rd_taken;
    send_cmd(addr, 1'b1);
    await_signal(SEL_RD_VALID, "rd_valid_o");
    held = rd_data_o;
    // byte must stay put while the host is not ready
    hold = $unsigned($random(seed)) % 24;
    repeat (hold) begin
      @(negedge clk);
      check_bit("rd_valid_o", rd_valid_o, 1'b1);
      check_byte("rd_data_o (held)", rd_data_o, held);
    end
    @(posedge clk);
    #2;
    rd_ready_i = 1'b1;
    @(posedge clk);
    #2;
    rd_ready_i = 1'b0;
    await_signal(SEL_IDLE, "busy_o to fall");
    check_byte("read handshakes", i2c_pkg::byte_t'(rd_taken - taken), 8'd1);
  endtask

  task automatic check_model_burst();
    check_byte("target burst length", i2c_pkg::byte_t'(i_target.burst_len),
               i2c_pkg::byte_t'(burst_q.size()));
    foreach (burst_q[i]) begin
      check_byte($sformatf("i_target.mem[%0d]", i), i_target.mem[i], burst_q[i]);
    end
  endtask

  // read data compared on the handshake
  always @(negedge clk) begin
    if (rd_valid_o && rd_ready_i) begin
      check_byte("rd_data_o", rd_data_o, exp_rd);
      check_bit("rd_last_o", rd_last_o, 1'b1);
      rd_taken++;
    end
  end

  always @(negedge clk) begin
    if (rst_n && missed_ack_o) begin
      miss_cycles++;
    end
    if (rst_n && rd_valid_o) begin
      rd_valid_cycles++;
    end
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired at %0t ns, the transactions never finished", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int n_bytes;
    int miss0;
    int valid0;
    seed            = 32'h8c3c;
    checks          = 0;
    value_errs      = 0;
    other_errs      = 0;
    miss_cycles     = 0;
    rd_valid_cycles = 0;
    rd_taken        = 0;
    exp_rd          = '0;
    rst_n           = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_addr_i      = '0;
    cmd_read_i      = 1'b0;
    wr_data_i       = '0;
    wr_last_i       = 1'b0;
    wr_valid_i      = 1'b0;
    rd_ready_i      = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // idle bus after reset
    @(negedge clk);
    check_bit("scl_o", dut_scl, 1'b1);
    check_bit("sda_o", dut_sda, 1'b1);
    check_bit("busy_o", busy_o, 1'b0);
    await_signal(SEL_CMD_READY, "cmd_ready_o after reset");

    // single byte write
    burst_q = {8'ha5};
    write_burst(7'h50, 0);
    check_byte("missed_ack_o cycles", i2c_pkg::byte_t'(miss_cycles), 8'd0);
    check_model_burst();

    // random bursts each read back as a checksum
    for (int t = 0; t < 8; t++) begin
      n_bytes = 1 + $unsigned($random(seed)) % 4;
      burst_q.delete();
      repeat (n_bytes) burst_q.push_back(i2c_pkg::byte_t'($random(seed)));
      write_burst(7'h50, 30);
      check_model_burst();
      read_check(7'h50);
    end
    check_byte("missed_ack_o cycles", i2c_pkg::byte_t'(miss_cycles), 8'd0);

    // whole burst drained for an absent target
    burst_q = {8'h11, 8'h22, 8'h33};
    miss0   = miss_cycles;
    valid0  = rd_valid_cycles;
    write_burst(7'h23, 8);
    check_byte("missed_ack_o cycles", i2c_pkg::byte_t'(miss_cycles - miss0), 8'd1);
    check_byte("rd_valid_o cycles", i2c_pkg::byte_t'(rd_valid_cycles - valid0), 8'd0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("scl_o", dut_scl, 1'b1);
    check_bit("sda_o", dut_sda, 1'b1);
    check_bit("scl", scl, 1'b1);
    check_bit("sda", sda, 1'b1);

    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/i2c_pkg.sv
hdl/i2c_bit_phy.sv
hdl/i2c_byte_ctrl.sv
hdl/i2c_master.sv
test/i2c_target_model.sv
test/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the i2c master testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module tb_i2c_master -f filelist.f -o tb_i2c_master
./obj_dir/tb_i2c_master 2>&1 | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "result: passed"
else
  echo "result: failed"
  exit 1
fi
